//--- common/inv_sqrt_defs.svh
// ========================================
// constants for the reciprocal sqrt unit
// fixed-point format, vector length, depth
// ========================================
`ifndef INV_SQRT_DEFS_SVH
`define INV_SQRT_DEFS_SVH

// Q5.10 fraction width
`define INV_SQRT_FRAC_BITS 10

// elements in the difference vector
`define INV_SQRT_DIFF_LEN 16

// stages from input to output register
`define INV_SQRT_NUM_STAGES 9

// 3.0 in Q5.10
`define INV_SQRT_THREE 16'h0C00

`endif

//--- common/fixed_pkg.sv
// ========================================
// fixed-point types for Q5.10 arithmetic
// ========================================
`default_nettype none

package fixed_pkg;

    // ========================================
    // widths
    // ========================================
    localparam int Q_WIDTH = 16;

    // signed value, 10 fraction bits
    typedef logic signed [Q_WIDTH-1:0] q5_10_t;

    // full product of two Q5.10 values (Q10.20)
    typedef logic signed [2*Q_WIDTH-1:0] q_prod_t;

endpackage

`default_nettype wire

//--- common/pipe_pkg.sv
// ========================================
// pipeline types: stage enables and the
// difference-vector payload
// ========================================
`default_nettype none

`include "inv_sqrt_defs.svh"

package pipe_pkg;

    import fixed_pkg::*;

    // one load enable per stage, bit 0 = seed, top bit = output
    typedef logic [`INV_SQRT_NUM_STAGES-1:0] stage_en_t;

    // difference vector carried beside the math
    typedef q5_10_t [`INV_SQRT_DIFF_LEN-1:0] diff_vec_t;

endpackage

`default_nettype wire

//--- logic/stage_ctrl.sv
// ========================================
// valid shift register, one load enable
// per pipeline stage plus output valid
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "inv_sqrt_defs.svh"

module stage_ctrl
    import pipe_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      valid_in,
    output stage_en_t      stage_en,
    output logic           valid_out
);

    localparam int NS = `INV_SQRT_NUM_STAGES;

    // valid_sr[k] is valid_in delayed by k cycles
    logic [NS-1:1] valid_sr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_sr  <= '0;
            valid_out <= 1'b0;
        end else begin
            valid_sr  <= {valid_sr[NS-2:1], valid_in};
            valid_out <= valid_sr[NS-1];  // lines up with output register
        end
    end

    // bit 0 is the live strobe, seed stage loads on it
    assign stage_en = {valid_sr, valid_in};

endmodule

`default_nettype wire

//--- logic/sideband_delay.sv
// ========================================
// enable-gated delay line for data that
// travels beside the datapath
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "inv_sqrt_defs.svh"

module sideband_delay
    import pipe_pkg::*;
#(
    parameter type payload_t = logic
) (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire stage_en_t stage_en,
    input  wire payload_t  data_in,
    output payload_t       data_out
);

    localparam int NS = `INV_SQRT_NUM_STAGES;

    payload_t pipe_q [NS];  // one slot per stage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < NS; k++) begin
                pipe_q[k] <= '0;
            end
        end else begin
            if (stage_en[0]) pipe_q[0] <= data_in;
            // each slot follows its own stage, holds otherwise
            for (int k = 1; k < NS; k++) begin
                if (stage_en[k]) pipe_q[k] <= pipe_q[k-1];
            end
        end
    end

    assign data_out = pipe_q[NS-1];

endmodule

`default_nettype wire

//--- inv_sqrt/seed_lut.sv
// ========================================
// initial guess for 1/sqrt(v), looked up
// from the upper byte of the variance
// ========================================
`timescale 1ns/1ps
`default_nettype none

module seed_lut
    import fixed_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire logic   en,
    input  wire q5_10_t variance_in,
    output q5_10_t      variance_out,
    output q5_10_t      x0
);

    q5_10_t seed;

    // ========================================
    // seed table
    // ========================================
    // coarse steps over small variances, a few spot
    // entries above, 0.25 for everything else
    always_comb begin
        case (variance_in[15:8])
            8'h00:                      seed = 16'sh0C00;  // ~3.0
            8'h01:                      seed = 16'sh0800;  // ~2.0
            8'h02:                      seed = 16'sh0599;  // ~1.4
            8'h03:                      seed = 16'sh0466;  // ~1.1
            8'h04:                      seed = 16'sh0400;  // 1.0
            8'h05:                      seed = 16'sh0399;  // ~0.9
            8'h06:                      seed = 16'sh0333;  // ~0.8
            8'h07, 8'h08:               seed = 16'sh02CC;  // ~0.7
            8'h09, 8'h0A, 8'h0B, 8'h0C: seed = 16'sh0266;  // ~0.6
            8'h0D, 8'h0E, 8'h0F, 8'h10: seed = 16'sh0200;  // 0.5
            8'h28:                      seed = 16'sh0133;  // var near 10
            8'h40:                      seed = 16'sh00CC;  // var near 16
            default:                    seed = 16'sh0100;  // 0.25
        endcase
    end

    // ========================================
    // stage 0 register
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            variance_out <= '0;
            x0           <= '0;
        end else if (en) begin
            variance_out <= variance_in;
            x0           <= seed;
        end
    end

endmodule

`default_nettype wire

//--- inv_sqrt/newton_iter.sv
// ========================================
// one Newton step for 1/sqrt(v):
// x' = x * (3 - v * x^2) / 2, four stages
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "inv_sqrt_defs.svh"

module newton_iter
    import fixed_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic [3:0] en,
    input  wire q5_10_t     variance_in,
    input  wire q5_10_t     x_in,
    output q5_10_t          variance_out,
    output q5_10_t          x_out
);

    localparam int FRAC = `INV_SQRT_FRAC_BITS;

    // stage results
    q5_10_t x_sq;       // x^2
    q5_10_t var_x_sq;   // v * x^2
    q5_10_t three_sub;  // 3 - v * x^2

    // operands delayed alongside
    q5_10_t x_d1, x_d2, x_d3;
    q5_10_t var_d1, var_d2, var_d3;

    // full-width products
    q_prod_t prod_sq;
    q_prod_t prod_var;
    q_prod_t prod_out;

    assign prod_sq  = x_in * x_in;
    assign prod_var = var_d1 * x_sq;
    assign prod_out = x_d3 * three_sub;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_sq         <= '0;
            var_x_sq     <= '0;
            three_sub    <= '0;
            x_d1         <= '0;
            x_d2         <= '0;
            x_d3         <= '0;
            var_d1       <= '0;
            var_d2       <= '0;
            var_d3       <= '0;
            x_out        <= '0;
            variance_out <= '0;
        end else begin
            // ========================================
            // square, scale, subtract, multiply
            // ========================================
            if (en[0]) begin
                x_sq   <= q5_10_t'(prod_sq >>> FRAC);  // keep low 16 bits
                x_d1   <= x_in;
                var_d1 <= variance_in;
            end
            if (en[1]) begin
                var_x_sq <= q5_10_t'(prod_var >>> FRAC);
                x_d2     <= x_d1;
                var_d2   <= var_d1;
            end
            if (en[2]) begin
                three_sub <= q5_10_t'(`INV_SQRT_THREE) - var_x_sq;
                x_d3      <= x_d2;
                var_d3    <= var_d2;
            end
            if (en[3]) begin
                // extra bit of shift does the divide by two
                x_out        <= q5_10_t'(prod_out >>> (FRAC + 1));
                variance_out <= var_d3;
            end
        end
    end

endmodule

`default_nettype wire

//--- inv_sqrt/inv_sqrt_top.sv
// ========================================
// reciprocal sqrt pipeline: seed lookup,
// two Newton steps, sideband delay lines
// ========================================
`timescale 1ns/1ps
`default_nettype none

module inv_sqrt_top
    import fixed_pkg::*;
    import pipe_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      valid_in,
    input  wire q5_10_t    variance_in,
    input  wire q5_10_t    mean_in,
    input  wire diff_vec_t diff_in,
    output logic           valid_out,
    output q5_10_t         inv_sigma,
    output q5_10_t         mean_out,
    output diff_vec_t      diff_out
);

    stage_en_t stage_en;

    q5_10_t var_s0, x0;  // seed stage out
    q5_10_t var_s4, x1;  // first iteration out

    // ========================================
    // control
    // ========================================
    stage_ctrl ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .stage_en  (stage_en),
        .valid_out (valid_out)
    );

    // ========================================
    // datapath
    // ========================================
    seed_lut seed_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (stage_en[0]),
        .variance_in  (variance_in),
        .variance_out (var_s0),
        .x0           (x0)
    );

    newton_iter iter1_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (stage_en[4:1]),
        .variance_in  (var_s0),
        .x_in         (x0),
        .variance_out (var_s4),
        .x_out        (x1)
    );

    // variance not needed past the last step
    newton_iter iter2_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (stage_en[8:5]),
        .variance_in  (var_s4),
        .x_in         (x1),
        .variance_out (),
        .x_out        (inv_sigma)
    );

    // ========================================
    // sideband
    // ========================================
    sideband_delay #(.payload_t(q5_10_t)) mean_dly_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .stage_en (stage_en),
        .data_in  (mean_in),
        .data_out (mean_out)
    );

    sideband_delay #(.payload_t(diff_vec_t)) diff_dly_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .stage_en (stage_en),
        .data_in  (diff_in),
        .data_out (diff_out)
    );

endmodule

`default_nettype wire

//--- dv/inv_sqrt_props.sv
// ========================================
// bound assertions: valid latency, quiet
// reset, known result
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "inv_sqrt_defs.svh"

module inv_sqrt_props
    import fixed_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire logic   valid_in,
    input  wire logic   valid_out,
    input  wire q5_10_t inv_sigma
);

    int latency_fails;
    int reset_fails;
    int unknown_fails;
    int fail_count;

    assign fail_count = latency_fails + reset_fails + unknown_fails;

    // valid travels through the full pipeline depth
    latency_a: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out == $past(valid_in, `INV_SQRT_NUM_STAGES))
        else begin
            latency_fails++;
            $error("valid_out does not follow valid_in by the pipeline depth");
        end

    reset_quiet_a: assert property (@(posedge clk) !rst_n |-> !valid_out)
        else begin
            reset_fails++;
            $error("valid_out high during reset");
        end

    known_sigma_a: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out |-> !$isunknown(inv_sigma))
        else begin
            unknown_fails++;
            $error("inv_sigma has unknown bits while valid_out is high");
        end

endmodule

bind inv_sqrt_top inv_sqrt_props props_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_in  (valid_in),
    .valid_out (valid_out),
    .inv_sigma (inv_sigma)
);

`default_nettype wire

//--- dv/inv_sqrt_checker.sv
// ========================================
// result checker: reference model, queue
// of expected results, hold check
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "inv_sqrt_defs.svh"

module inv_sqrt_checker
    import fixed_pkg::*;
    import pipe_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      valid_in,
    input  wire q5_10_t    variance_in,
    input  wire q5_10_t    mean_in,
    input  wire diff_vec_t diff_in,
    input  wire logic      valid_out,
    input  wire q5_10_t    inv_sigma,
    input  wire q5_10_t    mean_out,
    input  wire diff_vec_t diff_out,
    output int             value_errors,
    output int             protocol_errors,
    output int             checked,
    output int             pending
);

    localparam int FRAC    = `INV_SQRT_FRAC_BITS;
    localparam int LATENCY = `INV_SQRT_NUM_STAGES;
    localparam int THREE_Q = int'(`INV_SQRT_THREE);

    q5_10_t    exp_sigma_q [$];
    q5_10_t    exp_mean_q [$];
    q5_10_t    exp_var_q [$];
    diff_vec_t exp_diff_q [$];
    int        exp_cycle_q [$];  // input cycle of each entry

    int        cycle;
    logic      have_last;
    q5_10_t    last_sigma;
    q5_10_t    last_mean;
    diff_vec_t last_diff;

    // ========================================
    // reference model
    // ========================================
    function automatic q5_10_t seed_for(input logic [7:0] ub);
        if (ub == 8'h00) return 16'sh0C00;
        if (ub == 8'h01) return 16'sh0800;
        if (ub == 8'h02) return 16'sh0599;
        if (ub == 8'h03) return 16'sh0466;
        if (ub == 8'h04) return 16'sh0400;
        if (ub == 8'h05) return 16'sh0399;
        if (ub == 8'h06) return 16'sh0333;
        if (ub >= 8'h07 && ub <= 8'h08) return 16'sh02CC;
        if (ub >= 8'h09 && ub <= 8'h0C) return 16'sh0266;
        if (ub >= 8'h0D && ub <= 8'h10) return 16'sh0200;
        if (ub == 8'h28) return 16'sh0133;
        if (ub == 8'h40) return 16'sh00CC;
        return 16'sh0100;  // default guess 0.25
    endfunction

    // x * (3 - v * x^2) / 2, every step cut to 16 bits
    function automatic q5_10_t newton_step(input q5_10_t v, input q5_10_t x);
        int     p;
        q5_10_t sq;
        q5_10_t vsq;
        q5_10_t diff;
        p    = int'(x) * int'(x);
        sq   = q5_10_t'(p >>> FRAC);
        p    = int'(v) * int'(sq);
        vsq  = q5_10_t'(p >>> FRAC);
        diff = q5_10_t'(THREE_Q - int'(vsq));
        p    = int'(x) * int'(diff);
        return q5_10_t'(p >>> (FRAC + 1));
    endfunction

    function automatic q5_10_t ref_inv_sqrt(input q5_10_t v);
        return newton_step(v, newton_step(v, seed_for(v[15:8])));
    endfunction

    // ========================================
    // comparisons
    // ========================================
    task automatic compare_result();
        q5_10_t    e_sig;
        q5_10_t    e_mean;
        q5_10_t    e_var;
        diff_vec_t e_diff;
        int        stamp;
        if (exp_sigma_q.size() == 0) begin
            $display("valid_out high at cycle %0d with no input waiting for it", cycle);
            protocol_errors++;
            return;
        end
        e_sig  = exp_sigma_q.pop_front();
        e_mean = exp_mean_q.pop_front();
        e_var  = exp_var_q.pop_front();
        e_diff = exp_diff_q.pop_front();
        stamp  = exp_cycle_q.pop_front();
        checked++;
        if (cycle - stamp != LATENCY) begin
            $display("result came out %0d cycles after its input, expected %0d",
                     cycle - stamp, LATENCY);
            protocol_errors++;
        end
        if (inv_sigma !== e_sig) begin
            $display("ERROR inv_sigma: got %h expected %h (variance %h)",
                     inv_sigma, e_sig, e_var);
            value_errors++;
        end
        if (mean_out !== e_mean) begin
            $display("ERROR mean_out: got %h expected %h", mean_out, e_mean);
            value_errors++;
        end
        if (diff_out !== e_diff) begin
            $display("ERROR diff_out: got %h expected %h", diff_out, e_diff);
            value_errors++;
        end
    endtask

    // outputs stay put between results
    task automatic check_hold();
        if (inv_sigma !== last_sigma) begin
            $display("ERROR inv_sigma: changed from %h to %h without valid_out",
                     last_sigma, inv_sigma);
            value_errors++;
        end
        if (mean_out !== last_mean) begin
            $display("ERROR mean_out: changed from %h to %h without valid_out",
                     last_mean, mean_out);
            value_errors++;
        end
        if (diff_out !== last_diff) begin
            $display("ERROR diff_out: changed from %h to %h without valid_out",
                     last_diff, diff_out);
            value_errors++;
        end
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (!rst_n) begin
            have_last = 1'b0;
        end else begin
            if (valid_in) begin
                exp_sigma_q.push_back(ref_inv_sqrt(variance_in));
                exp_mean_q.push_back(mean_in);
                exp_var_q.push_back(variance_in);
                exp_diff_q.push_back(diff_in);
                exp_cycle_q.push_back(cycle);
            end
            if (valid_out)
                compare_result();
            else if (have_last)
                check_hold();
            last_sigma = inv_sigma;
            last_mean  = mean_out;
            last_diff  = diff_out;
            have_last  = 1'b1;
            pending    = exp_sigma_q.size();
        end
    end

endmodule

`default_nettype wire

//--- dv/inv_sqrt_tb.sv
// ========================================
// testbench top with clock, reset,
// stimulus, timeout and closing report
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "inv_sqrt_defs.svh"

module inv_sqrt_tb
    import fixed_pkg::*;
    import pipe_pkg::*;
();

    localparam int RESET_CYCLES = 4;
    localparam int TABLE_ITEMS  = 28;  // 17 listed bytes plus 11 extra
    localparam int BURST_ITEMS  = 64;
    localparam int GAP_ITEMS    = 40;
    localparam int MAX_GAP      = 3;
    localparam int SETTLE       = 4;
    localparam int PHASES       = 4;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 1 + 2 * TABLE_ITEMS + BURST_ITEMS
        + (1 + MAX_GAP) * GAP_ITEMS + PHASES * (`INV_SQRT_NUM_STAGES + 1 + SETTLE) + 50;
    localparam logic [31:0] LCG_SEED = 32'hdc14_ea1b;
    localparam logic [7:0] EXTRA_BYTES [11] = '{8'h28, 8'h40, 8'h11, 8'h1F, 8'h27,
                                                8'h29, 8'h3F, 8'h41, 8'h7F, 8'h80, 8'hFF};

    logic      clk;
    logic      rst_n;
    logic      valid_in;
    q5_10_t    variance_in;
    q5_10_t    mean_in;
    diff_vec_t diff_in;
    logic      valid_out;
    q5_10_t    inv_sigma;
    q5_10_t    mean_out;
    diff_vec_t diff_out;

    logic [31:0] lcg_state;
    int          sent_count;
    int          cycle_cnt;
    int          chk_value_err;
    int          chk_protocol_err;
    int          chk_checked;
    int          chk_pending;
    int          assert_fails;
    int          total_errors;

    inv_sqrt_top dut_i (
        .clk (clk), .rst_n (rst_n), .valid_in (valid_in), .variance_in (variance_in),
        .mean_in (mean_in), .diff_in (diff_in), .valid_out (valid_out),
        .inv_sigma (inv_sigma), .mean_out (mean_out), .diff_out (diff_out)
    );

    inv_sqrt_checker chk_i (
        .clk (clk), .rst_n (rst_n), .valid_in (valid_in), .variance_in (variance_in),
        .mean_in (mean_in), .diff_in (diff_in), .valid_out (valid_out),
        .inv_sigma (inv_sigma), .mean_out (mean_out), .diff_out (diff_out),
        .value_errors (chk_value_err), .protocol_errors (chk_protocol_err),
        .checked (chk_checked), .pending (chk_pending)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ========================================
    // stimulus helpers
    // ========================================
    function automatic logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic diff_vec_t rand_diff();
        diff_vec_t d;
        for (int i = 0; i < `INV_SQRT_DIFF_LEN; i++) d[i] = q5_10_t'(rand32() >> 16);
        return d;
    endfunction

    task automatic send(input q5_10_t v, input q5_10_t m, input diff_vec_t d);
        @(posedge clk);
        #1;
        valid_in    = 1'b1;
        variance_in = v;
        mean_in     = m;
        diff_in     = d;
        sent_count++;
    endtask

    task automatic send_random();
        logic [31:0] r_var;
        logic [31:0] r_mean;
        r_var  = rand32();
        r_mean = rand32();
        send({1'b0, r_var[30:16]}, r_mean[31:16], rand_diff());
    endtask

    task automatic idle(input int n);
        logic [31:0] r;
        repeat (n) begin
            @(posedge clk);
            #1;
            r           = rand32();
            valid_in    = 1'b0;
            variance_in = r[31:16];  // junk that must be ignored
            mean_in     = r[23:8];
        end
    endtask

    // wait until every input has come back out
    task automatic drain();
        idle(1);
        while (chk_checked != sent_count) @(negedge clk);
        idle(SETTLE);
    endtask

    // ========================================
    // test sequence
    // ========================================
    initial begin
        logic [31:0] r;
        lcg_state   = LCG_SEED;
        rst_n       = 1'b0;
        valid_in    = 1'b0;
        variance_in = '0;
        mean_in     = '0;
        diff_in     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        send(16'sh0400, q5_10_t'(rand32() >> 16), rand_diff());  // lone item with v = 1.0
        drain();

        for (int b = 0; b <= 16; b++) begin
            r = rand32();
            send({8'(b), r[23:16]}, r[31:16], rand_diff());
            idle(1);
        end
        foreach (EXTRA_BYTES[i]) begin
            r = rand32();
            send({EXTRA_BYTES[i], r[23:16]}, r[31:16], rand_diff());
            idle(1);
        end
        drain();

        repeat (BURST_ITEMS) send_random();  // back to back
        drain();

        repeat (GAP_ITEMS) begin
            send_random();
            r = rand32();
            idle(int'(r[17:16]));
        end
        drain();

        if (chk_pending != 0)
            $display("%0d expected results never left the DUT", chk_pending);
        assert_fails = dut_i.props_i.fail_count;
        total_errors = chk_value_err + chk_protocol_err + assert_fails + chk_pending;
        $display("checked %0d of %0d: %0d value, %0d protocol, %0d assertion errors",
                 chk_checked, sent_count, chk_value_err, chk_protocol_err, assert_fails);
        if (total_errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    // ========================================
    // timeout
    // ========================================
    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("run stopped after %0d cycles without finishing", cycle_cnt);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- inv_sqrt.f
+incdir+common
common/fixed_pkg.sv
common/pipe_pkg.sv
logic/stage_ctrl.sv
logic/sideband_delay.sv
inv_sqrt/seed_lut.sv
inv_sqrt/newton_iter.sv
inv_sqrt/inv_sqrt_top.sv
dv/inv_sqrt_props.sv
dv/inv_sqrt_checker.sv
dv/inv_sqrt_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the reciprocal sqrt testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f inv_sqrt.f \
    --top-module inv_sqrt_tb -o sim_inv_sqrt
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

# keep running past assertion errors so the testbench can report them
out=$(./obj_dir/sim_inv_sqrt +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1
